/* build.f */
design/soc_pkg.sv
design/wb_if.sv
design/dbus_manager.sv
design/wb_decoder.sv
design/data_ram.sv
design/gpio_port.sv
design/soc_bus.sv
verification/soc_bus_props.sv
verification/soc_bus_tb.sv

/* build.sh */
#!/bin/sh
# Build and run the soc_bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module soc_bus_tb -f build.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vsoc_bus_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi
exit 0

/* verification/soc_bus_tb.sv */
module soc_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_pkg::*;

    localparam int RAM_WORDS = 2 ** RAM_ADDR_WIDTH;
    localparam int RAM_BYTES = 4 * RAM_WORDS;
    localparam int RAND_ACCESSES = 200;
    localparam int ROUNDS = 3;                        // Per GPIO port and phase
    localparam int PIN_SETTLE = 3;                    // Synchronizer plus edge flop
    localparam logic [15:0] OFS_OUT = 16'h0;
    localparam logic [15:0] OFS_DIR = 16'h4;
    localparam logic [15:0] OFS_IN = 16'h8;
    localparam logic [15:0] OFS_IRQ = 16'hc;
    // Fill, random writes and reads, GPIO phases, fault neighbours
    localparam int MAPPED_ACCESSES = RAM_WORDS + 2 * RAND_ACCESSES + 2 * ROUNDS * 10 + 2;
    localparam int FAULT_ACCESSES = 2;
    localparam int CYCLE_LIMIT = (MAPPED_ACCESSES * 5 + FAULT_ACCESSES * (BUS_TIMEOUT + 4)
                                  + 2 * ROUNDS * (PIN_SETTLE + 1) + 5) * 6 / 5;

    logic clk;
    logic reset;
    logic rd_en;
    logic wr_en;
    logic [ADDR_WIDTH-1:0] addr;
    logic [XLEN-1:0] wr_data;
    logic [STRB_WIDTH-1:0] wr_strobe;
    logic [XLEN-1:0] rd_data;
    logic access_fault;
    logic busy;
    logic [GPIO_PIN_COUNT-1:0] gpioa_in;
    logic [GPIO_PIN_COUNT-1:0] gpiob_in;
    logic [GPIO_PIN_COUNT-1:0] gpioa_out;
    logic [GPIO_PIN_COUNT-1:0] gpioa_oe;
    logic gpioa_int;
    logic [GPIO_PIN_COUNT-1:0] gpiob_out;
    logic [GPIO_PIN_COUNT-1:0] gpiob_oe;
    logic gpiob_int;

    // Reference state
    logic [31:0] ref_ram [RAM_WORDS];
    logic [15:0] ref_out [2];
    logic [15:0] ref_dir [2];
    logic [15:0] ref_in [2];
    logic [15:0] ref_irq [2];
    logic [31:0] exp_rd;
    logic exp_rd_valid;                               // rd_data defined after first read
    logic exp_fault;
    logic check_pending;
    logic [31:0] lcg_state;
    string test_name;
    int cycle_cnt;

    soc_bus u_soc_bus (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_mapped(input logic [15:0] a);
        return (32'(a) < RAM_BYTES) || (a[15:4] == GPIOA_BASE_ADDR[15:4])
               || (a[15:4] == GPIOB_BASE_ADDR[15:4]);
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [31:0] model_access(input logic wr, input logic [15:0] a,
                                                 input logic [31:0] d, input logic [3:0] s);
        logic [15:0] mask;
        logic [15:0] value;
        int p;
        if (32'(a) < RAM_BYTES) begin
            for (int b = 0; b < 4; b++) begin
                if (wr && s[b]) begin
                    ref_ram[a[9:2]][8*b +: 8] = d[8*b +: 8];   // Strobed byte merge
                end
            end
            return ref_ram[a[9:2]];
        end
        p = (a[15:4] == GPIOB_BASE_ADDR[15:4]) ? 1 : 0;
        mask = {{8{s[1]}}, {8{s[0]}}};                // Low two lanes carry the pins
        if (wr && a[3:2] == 2'd0) begin
            ref_out[p] = (ref_out[p] & ~mask) | (d[15:0] & mask);
        end
        if (wr && a[3:2] == 2'd1) begin
            ref_dir[p] = (ref_dir[p] & ~mask) | (d[15:0] & mask);
        end
        if (wr && a[3:2] == 2'd3) begin
            ref_irq[p] = ref_irq[p] & ~(d[15:0] & mask);   // Write one to clear
        end
        case (a[3:2])
            2'd0: value = ref_out[p];
            2'd1: value = ref_dir[p];
            2'd2: value = ref_in[p];
            default: value = ref_irq[p];
        endcase
        return {16'h0, value};
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_with_error($sformatf("mismatch %s %s: expected %h, actual %h",
                                      test_name, sig, expected, actual));
        end
    endtask

    ////////////////////
    // Compare process
    ////////////////////
    always @(negedge clk) begin                       // Away from the driving edge
        if (check_pending) begin
            check_value("busy", 32'h0, 32'(busy));
            check_value("access_fault", 32'(exp_fault), 32'(access_fault));
            if (exp_rd_valid) begin
                check_value("rd_data", exp_rd, rd_data);
            end
            check_value("gpioa_out", 32'(ref_out[0]), 32'(gpioa_out));
            check_value("gpioa_oe", 32'(ref_dir[0]), 32'(gpioa_oe));
            check_value("gpioa_int", 32'(|ref_irq[0]), 32'(gpioa_int));
            check_value("gpiob_out", 32'(ref_out[1]), 32'(gpiob_out));
            check_value("gpiob_oe", 32'(ref_dir[1]), 32'(gpiob_oe));
            check_value("gpiob_int", 32'(|ref_irq[1]), 32'(gpiob_int));
            check_pending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            stop_with_error("run exceeded its cycle limit without finishing");
        end
    end

    task automatic run_check();
        check_pending = 1'b1;
        wait (!check_pending);
    endtask

    // One request pulse, then wait for busy to fall
    task automatic bus_access(input logic wr, input logic [15:0] a,
                              input logic [31:0] d, input logic [3:0] s);
        int cycles;
        int expect_cycles;
        logic [31:0] word;
        cycles = 0;
        expect_cycles = is_mapped(a) ? 4 : BUS_TIMEOUT + 3;
        @(posedge clk);
        #1;
        addr = a;
        wr_data = d;
        wr_strobe = s;
        rd_en = !wr;
        wr_en = wr;
        do begin
            @(posedge clk);
            #1;
            rd_en = 1'b0;                             // Single-cycle pulse
            wr_en = 1'b0;
            cycles++;
        end while (busy);
        assert (cycles == expect_cycles) else begin
            stop_with_error($sformatf("mismatch %s access cycles: expected %0d, actual %0d",
                                      test_name, expect_cycles, cycles));
        end
        exp_fault = !is_mapped(a);
        if (is_mapped(a)) begin
            word = model_access(wr, a, d, s);
            if (!wr) begin
                exp_rd = word;
                exp_rd_valid = 1'b1;
            end
        end
        run_check();
    endtask

    task automatic drive_pins(input int p, input logic [15:0] v);
        @(posedge clk);
        #1;
        if (p == 0) begin
            gpioa_in = v;
        end else begin
            gpiob_in = v;
        end
        ref_irq[p] = ref_irq[p] | (v & ~ref_in[p]);   // Zero-to-one bits
        ref_in[p] = v;
        repeat (PIN_SETTLE) @(posedge clk);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        logic [31:0] r;
        logic [15:0] base;
        reset = 1'b1;
        rd_en = 1'b0;
        wr_en = 1'b0;
        addr = '0;
        wr_data = '0;
        wr_strobe = '0;
        gpioa_in = '0;
        gpiob_in = '0;
        lcg_state = 32'haa60_743d;
        cycle_cnt = 0;
        check_pending = 1'b0;
        exp_rd = '0;
        exp_rd_valid = 1'b0;
        exp_fault = 1'b0;
        for (int p = 0; p < 2; p++) begin
            ref_out[p] = '0;
            ref_dir[p] = '0;
            ref_in[p] = '0;
            ref_irq[p] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        test_name = "reset";
        run_check();

        test_name = "ram fill";                       // Full words, no unknown bytes left
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_access(1'b1, 16'(i * 4), lcg_next(), 4'hf);
        end
        test_name = "ram write";
        for (int i = 0; i < RAND_ACCESSES; i++) begin
            r = lcg_next();
            bus_access(1'b1, {6'd0, r[9:2], 2'b00}, lcg_next(), r[13:10]);
        end
        test_name = "ram read";
        for (int i = 0; i < RAND_ACCESSES; i++) begin
            r = lcg_next();
            bus_access(1'b0, {6'd0, r[9:2], 2'b00}, 32'h0, 4'h0);
        end

        for (int p = 0; p < 2; p++) begin
            base = (p == 1) ? GPIOB_BASE_ADDR : GPIOA_BASE_ADDR;
            for (int k = 0; k < ROUNDS; k++) begin
                test_name = "gpio output";
                r = lcg_next();
                bus_access(1'b1, base | OFS_OUT, lcg_next(), {2'b00, r[1:0]});
                bus_access(1'b1, base | OFS_DIR, lcg_next(), 4'hf);
                bus_access(1'b0, base | OFS_OUT, 32'h0, 4'h0);
                bus_access(1'b0, base | OFS_DIR, 32'h0, 4'h0);
                test_name = "gpio input";
                r = lcg_next();
                drive_pins(p, r[15:0]);
                bus_access(1'b0, base | OFS_IN, 32'h0, 4'h0);
                bus_access(1'b0, base | OFS_IRQ, 32'h0, 4'h0);
                bus_access(1'b1, base | OFS_IRQ, {16'h0, r[31:16]}, 4'hf);   // Partial clear
                bus_access(1'b0, base | OFS_IRQ, 32'h0, 4'h0);
                bus_access(1'b1, base | OFS_IRQ, 32'h0000_ffff, 4'hf);
                bus_access(1'b0, base | OFS_IRQ, 32'h0, 4'h0);
            end
        end

        test_name = "fault";
        bus_access(1'b0, 16'h0010, 32'h0, 4'h0);      // Known rd_data first
        bus_access(1'b0, 16'h2000, 32'h0, 4'h0);
        bus_access(1'b1, 16'h3ffc, lcg_next(), 4'hf);
        test_name = "fault recovery";
        bus_access(1'b0, GPIOA_BASE_ADDR | OFS_OUT, 32'h0, 4'h0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* verification/soc_bus_props.sv */
module soc_bus_props (
    input logic clk,
    input logic reset,
    input logic rd_en,
    input logic wr_en,
    input logic busy,
    input logic timed_out,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic [soc_pkg::ADDR_WIDTH-1:0] adr
);
    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////
    // Core side
    ////////////////////
    no_request_while_busy: assert property (
        @(posedge clk) disable iff (reset) busy |-> !(rd_en || wr_en)
    ) else $error("request issued while busy is high");

    ////////////////////
    // Wishbone master
    ////////////////////
    stb_needs_cyc: assert property (
        @(posedge clk) disable iff (reset) stb |-> cyc
    ) else $error("stb high without cyc");

    // Held with a stable address until ack or the timeout
    cycle_held: assert property (
        @(posedge clk) disable iff (reset)
        cyc && stb && !ack && !timed_out |=> cyc && stb && $stable(adr)
    ) else $error("cycle dropped or address changed before ack");

    ack_in_cycle: assert property (
        @(posedge clk) disable iff (reset) ack |-> cyc && stb
    ) else $error("ack seen outside a bus cycle");

endmodule

bind dbus_manager soc_bus_props u_soc_bus_props (
    .clk,
    .reset,
    .rd_en,
    .wr_en,
    .busy,
    .timed_out,
    .cyc(bus.cyc),
    .stb(bus.stb),
    .ack(bus.ack),
    .adr(bus.adr)
);

/* design/soc_bus.sv */
module soc_bus (
    input  logic clk,
    input  logic reset,

    // Core data port
    input  logic rd_en,
    input  logic wr_en,
    input  logic [soc_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [soc_pkg::XLEN-1:0] wr_data,
    input  logic [soc_pkg::STRB_WIDTH-1:0] wr_strobe,
    output logic [soc_pkg::XLEN-1:0] rd_data,
    output logic access_fault,
    output logic busy,

    // GPIO pins, tristate split into in, out and oe
    input  logic [soc_pkg::GPIO_PIN_COUNT-1:0] gpioa_in,
    input  logic [soc_pkg::GPIO_PIN_COUNT-1:0] gpiob_in,
    output logic [soc_pkg::GPIO_PIN_COUNT-1:0] gpioa_out,
    output logic [soc_pkg::GPIO_PIN_COUNT-1:0] gpioa_oe,
    output logic gpioa_int,
    output logic [soc_pkg::GPIO_PIN_COUNT-1:0] gpiob_out,
    output logic [soc_pkg::GPIO_PIN_COUNT-1:0] gpiob_oe,
    output logic gpiob_int
);
    import soc_pkg::*;

    ////////////////////
    // Wishbone segments
    ////////////////////
    wb_if m_bus();                                    // Manager to decoder
    wb_if ram_bus();
    wb_if gpioa_bus();
    wb_if gpiob_bus();

    ////////////////////
    // Manager and decoder
    ////////////////////
    dbus_manager u_dbus_manager (
        .clk,
        .reset,
        .rd_en,
        .wr_en,
        .addr,
        .wr_data,
        .wr_strobe,
        .rd_data,
        .access_fault,
        .busy,
        .bus(m_bus.master)
    );

    wb_decoder u_wb_decoder (
        .m(m_bus.slave),
        .ram(ram_bus.master),
        .gpioa(gpioa_bus.master),
        .gpiob(gpiob_bus.master)
    );

    ////////////////////
    // Slaves
    ////////////////////
    data_ram u_data_ram (
        .clk,
        .reset,
        .bus(ram_bus.slave)
    );

    gpio_port #(
        .BASE_ADDR(GPIOA_BASE_ADDR)
    ) u_gpioa (
        .clk,
        .reset,
        .bus(gpioa_bus.slave),
        .pin_in(gpioa_in),
        .pin_out(gpioa_out),
        .pin_oe(gpioa_oe),
        .irq(gpioa_int)
    );

    gpio_port #(
        .BASE_ADDR(GPIOB_BASE_ADDR)
    ) u_gpiob (
        .clk,
        .reset,
        .bus(gpiob_bus.slave),
        .pin_in(gpiob_in),
        .pin_out(gpiob_out),
        .pin_oe(gpiob_oe),
        .irq(gpiob_int)
    );

endmodule

/* design/gpio_port.sv */
module gpio_port #(
    parameter logic [soc_pkg::ADDR_WIDTH-1:0] BASE_ADDR = soc_pkg::GPIOA_BASE_ADDR
) (
    input  logic clk,
    input  logic reset,
    wb_if.slave  bus,
    input  logic [soc_pkg::GPIO_PIN_COUNT-1:0] pin_in,
    output logic [soc_pkg::GPIO_PIN_COUNT-1:0] pin_out,
    output logic [soc_pkg::GPIO_PIN_COUNT-1:0] pin_oe,
    output logic irq
);
    import soc_pkg::*;

    logic [GPIO_PIN_COUNT-1:0] out_q;                 // reg_out
    logic [GPIO_PIN_COUNT-1:0] dir_q;                 // reg_dir
    logic [GPIO_PIN_COUNT-1:0] irq_q;                 // reg_irq
    logic [GPIO_PIN_COUNT-1:0] sync_meta;             // First synchronizer stage
    logic [GPIO_PIN_COUNT-1:0] sync_q;                // reg_in
    logic [GPIO_PIN_COUNT-1:0] sync_prev;             // For edge detect
    logic [GPIO_PIN_COUNT-1:0] rise;
    logic [GPIO_PIN_COUNT-1:0] wr_mask;               // Pins covered by sel
    logic [GPIO_PIN_COUNT-1:0] wr_bits;
    logic [GPIO_PIN_COUNT-1:0] irq_clr;
    logic [GPIO_PIN_COUNT-1:0] rd_value;
    logic [ADDR_WIDTH-1:0] win_addr;                  // Offset inside window
    gpio_reg_t reg_sel;
    logic access;
    logic wr_stb;

    assign win_addr = bus.adr - BASE_ADDR;
    assign reg_sel = gpio_reg_t'(win_addr[GPIO_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH]);
    assign access = bus.cyc & bus.stb & ~bus.ack;
    assign wr_stb = access & bus.we;
    assign wr_bits = bus.dat_w[GPIO_PIN_COUNT-1:0];   // Low half only

    always_comb begin
        for (int i = 0; i < GPIO_PIN_COUNT; i++) begin
            wr_mask[i] = bus.sel[i / 8];
        end
    end

    ////////////////////
    // Input path
    ////////////////////
    always_ff @(posedge clk) begin
        sync_meta <= pin_in;
        sync_q <= sync_meta;
        sync_prev <= sync_q;
    end

    assign rise = sync_q & ~sync_prev;                // Zero-to-one per pin
    assign irq_clr = (wr_stb && reg_sel == reg_irq) ? (wr_bits & wr_mask) : '0;

    ////////////////////
    // Registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            out_q <= '0;
            dir_q <= '0;
            irq_q <= '0;
        end else begin
            if (wr_stb && reg_sel == reg_out) begin
                out_q <= (out_q & ~wr_mask) | (wr_bits & wr_mask);
            end
            if (wr_stb && reg_sel == reg_dir) begin
                dir_q <= (dir_q & ~wr_mask) | (wr_bits & wr_mask);
            end
            irq_q <= (irq_q & ~irq_clr) | rise;       // A new edge beats the clear
        end
    end

    always_comb begin
        case (reg_sel)
            reg_out: rd_value = out_q;
            reg_dir: rd_value = dir_q;
            reg_in:  rd_value = sync_q;
            reg_irq: rd_value = irq_q;
            default: rd_value = '0;
        endcase
    end

    // Response, one cycle after strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= {{(XLEN - GPIO_PIN_COUNT){1'b0}}, rd_value};
        end
    end

    assign pin_out = out_q;
    assign pin_oe = dir_q;
    assign irq = |irq_q;                              // Level, any pending bit

endmodule

/* design/data_ram.sv */
module data_ram (
    input logic clk,
    input logic reset,
    wb_if.slave bus
);
    import soc_pkg::*;

    localparam int RAM_WORDS = 2 ** RAM_ADDR_WIDTH;

    logic [XLEN-1:0] mem [RAM_WORDS];                 // Word array
    logic [RAM_ADDR_WIDTH-1:0] word_addr;
    logic access;                                     // New transfer this cycle

    // Byte address to word index
    assign word_addr = bus.adr[RAM_WINDOW_WIDTH-1:BYTE_OFFSET_WIDTH];

    // Strobe with ack low, so each transfer is taken once
    assign access = bus.cyc & bus.stb & ~bus.ack;

    ////////////////////
    // Acknowledge
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;                        // Single-cycle pulse
        end
    end

    ////////////////////
    // Array access
    ////////////////////
    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                // Only the enabled byte lanes change
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (bus.sel[b]) begin
                        mem[word_addr][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end
            bus.dat_r <= mem[word_addr];              // Whole word, with ack
        end
    end

endmodule

/* design/wb_decoder.sv */
module wb_decoder (
    wb_if.slave  m,
    wb_if.master ram,
    wb_if.master gpioa,
    wb_if.master gpiob
);
    import soc_pkg::*;

    logic ram_hit;
    logic gpioa_hit;
    logic gpiob_hit;

    ////////////////////
    // Window match
    ////////////////////
    // Upper bits only, windows are size aligned
    assign ram_hit = m.adr[ADDR_WIDTH-1:RAM_WINDOW_WIDTH]
                     == RAM_BASE_ADDR[ADDR_WIDTH-1:RAM_WINDOW_WIDTH];
    assign gpioa_hit = m.adr[ADDR_WIDTH-1:GPIO_ADDR_WIDTH]
                       == GPIOA_BASE_ADDR[ADDR_WIDTH-1:GPIO_ADDR_WIDTH];
    assign gpiob_hit = m.adr[ADDR_WIDTH-1:GPIO_ADDR_WIDTH]
                       == GPIOB_BASE_ADDR[ADDR_WIDTH-1:GPIO_ADDR_WIDTH];

    ////////////////////
    // Request fan-out
    ////////////////////
    // Cycle and strobe go to the selected slave only
    assign ram.cyc = m.cyc & ram_hit;
    assign ram.stb = m.stb & ram_hit;
    assign gpioa.cyc = m.cyc & gpioa_hit;
    assign gpioa.stb = m.stb & gpioa_hit;
    assign gpiob.cyc = m.cyc & gpiob_hit;
    assign gpiob.stb = m.stb & gpiob_hit;

    // Shared request fields
    assign ram.adr = m.adr;
    assign ram.we = m.we;
    assign ram.dat_w = m.dat_w;
    assign ram.sel = m.sel;
    assign gpioa.adr = m.adr;
    assign gpioa.we = m.we;
    assign gpioa.dat_w = m.dat_w;
    assign gpioa.sel = m.sel;
    assign gpiob.adr = m.adr;
    assign gpiob.we = m.we;
    assign gpiob.dat_w = m.dat_w;
    assign gpiob.sel = m.sel;

    ////////////////////
    // Response mux
    ////////////////////
    always_comb begin
        m.dat_r = '0;
        m.ack = 1'b0;                                 // Unmapped: never acked
        if (ram_hit) begin
            m.dat_r = ram.dat_r;
            m.ack = ram.ack;
        end else if (gpioa_hit) begin
            m.dat_r = gpioa.dat_r;
            m.ack = gpioa.ack;
        end else if (gpiob_hit) begin
            m.dat_r = gpiob.dat_r;
            m.ack = gpiob.ack;
        end
    end

endmodule

/* design/dbus_manager.sv */
module dbus_manager (
    input  logic clk,
    input  logic reset,
    input  logic rd_en,
    input  logic wr_en,
    input  logic [soc_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [soc_pkg::XLEN-1:0] wr_data,
    input  logic [soc_pkg::STRB_WIDTH-1:0] wr_strobe,
    output logic [soc_pkg::XLEN-1:0] rd_data,
    output logic access_fault,
    output logic busy,
    wb_if.master bus
);
    import soc_pkg::*;

    bus_state_t state;
    logic [TIMEOUT_CNT_WIDTH-1:0] wait_cnt;           // Cycles spent without ack
    logic request;                                    // Accepted core request
    logic timed_out;

    assign request = (state == idle) && (rd_en || wr_en);
    assign timed_out = (wait_cnt == TIMEOUT_CNT_WIDTH'(BUS_TIMEOUT));

    ////////////////////
    // Control FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            busy <= 1'b0;
            access_fault <= 1'b0;
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            wait_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (request) begin
                        state <= cycle;
                        busy <= 1'b1;                 // Core stalls from here
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        wait_cnt <= '0;
                    end
                end
                cycle: begin
                    if (bus.ack) begin
                        state <= finish;
                        bus.cyc <= 1'b0;              // Drop right after ack
                        bus.stb <= 1'b0;
                        access_fault <= 1'b0;
                    end else if (timed_out) begin
                        // Nobody answered, abandon the cycle
                        state <= finish;
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        access_fault <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                finish: begin
                    state <= idle;
                    busy <= 1'b0;                     // Result visible to core
                end
                default: state <= idle;
            endcase
        end
    end

    ////////////////////
    // Request and response data
    ////////////////////
    always_ff @(posedge clk) begin
        if (request) begin
            bus.adr <= addr;
            bus.we <= wr_en;                          // Write wins if both pulse
            bus.dat_w <= wr_data;
            bus.sel <= wr_en ? wr_strobe : '1;        // Reads take the full word
        end
        // Read data captured with ack, kept on fault
        if ((state == cycle) && bus.ack && !bus.we) begin
            rd_data <= bus.dat_r;
        end
    end

endmodule

/* design/wb_if.sv */
interface wb_if;
    import soc_pkg::*;

    // Master to slave
    logic cyc;                                        // Cycle in progress
    logic stb;                                        // Transfer strobe
    logic we;                                         // Write enable
    logic [ADDR_WIDTH-1:0] adr;                       // Byte address
    logic [XLEN-1:0] dat_w;
    logic [STRB_WIDTH-1:0] sel;                       // Byte lanes

    // Slave to master
    logic [XLEN-1:0] dat_r;
    logic ack;                                        // One-cycle response

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface

/* design/soc_pkg.sv */
package soc_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int XLEN = 32;                         // Data word
    localparam int STRB_WIDTH = XLEN / 8;             // One strobe per byte
    localparam int ADDR_WIDTH = 16;                   // Byte address of the data port
    localparam int BYTE_OFFSET_WIDTH = $clog2(STRB_WIDTH);

    ////////////////////
    // Address map
    ////////////////////
    // RAM window, 256 words
    localparam int RAM_ADDR_WIDTH = 8;                // Word address
    localparam int RAM_WINDOW_WIDTH = RAM_ADDR_WIDTH + BYTE_OFFSET_WIDTH;
    localparam logic [ADDR_WIDTH-1:0] RAM_BASE_ADDR = 16'h0000;

    // GPIO windows, four word registers each
    localparam logic [ADDR_WIDTH-1:0] GPIOA_BASE_ADDR = 16'h1000;
    localparam logic [ADDR_WIDTH-1:0] GPIOB_BASE_ADDR = 16'h1100;
    localparam int GPIO_ADDR_WIDTH = 4;               // Byte address inside a window
    localparam int GPIO_PIN_COUNT = 16;
    localparam int GPIO_REG_SEL_WIDTH = GPIO_ADDR_WIDTH - BYTE_OFFSET_WIDTH;

    ////////////////////
    // Bus manager
    ////////////////////
    localparam int BUS_TIMEOUT = 16;                  // Cycles to wait for ack
    localparam int TIMEOUT_CNT_WIDTH = $clog2(BUS_TIMEOUT + 1);

    // Manager FSM
    typedef enum logic [1:0] {
        idle,                                         // Waiting for a request
        cycle,                                        // Wishbone cycle open
        finish                                        // Cycle closed, busy still high
    } bus_state_t;

    // GPIO register word offsets
    typedef enum logic [GPIO_REG_SEL_WIDTH-1:0] {
        reg_out,                                      // Pin output values
        reg_dir,                                      // Output enables
        reg_in,                                       // Synchronized pin inputs
        reg_irq                                       // Rising edge status, W1C
    } gpio_reg_t;

endpackage
